// ==== source/spike_delay_pkg.sv ====
package spike_delay_pkg;

    //////////////////////////////////////////////////////////////////////
    // spike delay line
    //////////////////////////////////////////////////////////////////////

    // delay of one line in clock cycles
    localparam int SPIKE_DELAY_CYCLES = 60;

    // ring size, next power of two at or above the delay
    localparam int SPIKE_RING_DEPTH = 64;

    // ring pointer width
    localparam int SPIKE_PTR_W = 6;

    //////////////////////////////////////////////////////////////////////
    // frame counting
    //////////////////////////////////////////////////////////////////////

    // cycles per counting frame
    localparam int FRAME_CYCLES = 16;

    // frame timer width
    localparam int FRAME_CNT_W = 4;

    // width of one spike count
    localparam int COUNT_W = 16;

    // one frame count
    typedef logic [COUNT_W-1:0] count_t;

    // frames the raw count is held back
    localparam int HISTORY_DEPTH = 31;

endpackage

// ==== source/spike_delay_line.sv ====
`timescale 1ns/100ps

module spike_delay_line
#(
    parameter int DELAY = spike_delay_pkg::SPIKE_DELAY_CYCLES,
    parameter int DEPTH = spike_delay_pkg::SPIKE_RING_DEPTH
)
(
    input  logic ep50trig,
    input  logic reset_global,
    input  logic i_spike,
    output logic o_spike
);

    import spike_delay_pkg::*;

    // pointer width follows the ring size
    localparam int PTR_W = $clog2(DEPTH);

    //////////////////////////////////////////////////////////////////////
    // ring storage and pointers
    //////////////////////////////////////////////////////////////////////

    // one bit per sampled edge
    logic             ring_mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;

    // set once DELAY samples are in the ring
    logic             ring_filled;

    // read trails write by DELAY entries, wraps with the pointer width
    assign rd_ptr = wr_ptr - PTR_W'(DELAY);

    // write side, one sample every cycle
    always_ff @(posedge ep50trig)
    begin
        ring_mem[wr_ptr] <= i_spike;
    end

    // pointer and fill flag
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            wr_ptr      <= '0;
            ring_filled <= 1'b0;
        end
        else
        begin
            // natural wrap for power-of-two depth
            if (wr_ptr == PTR_W'(DEPTH - 1))
                wr_ptr <= '0;
            else
                wr_ptr <= wr_ptr + 1'b1;

            // DELAY-th write lands here, flag sticks afterwards
            if (wr_ptr == PTR_W'(DELAY - 1))
                ring_filled <= 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // registered read
    //////////////////////////////////////////////////////////////////////

    // zero until the ring holds a full delay of samples
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
            o_spike <= 1'b0;
        else if (ring_filled)
            o_spike <= ring_mem[rd_ptr];
        else
            o_spike <= 1'b0;
    end

endmodule

// ==== source/spike_frame_counter.sv ====
`timescale 1ns/100ps

module spike_frame_counter
(
    input  logic                    ep50trig,
    input  logic                    reset_global,
    input  logic                    i_spike_raw,
    input  logic                    i_spike_delayed,
    input  logic                    i_spike_delayed_twice,
    output logic                    o_frame_valid,
    output spike_delay_pkg::count_t o_count_raw,
    output spike_delay_pkg::count_t o_count_delayed,
    output spike_delay_pkg::count_t o_count_delayed_twice
);

    import spike_delay_pkg::*;

    // raw, delayed, delayed twice
    localparam int NUM_CH = 3;

    //////////////////////////////////////////////////////////////////////
    // frame timer
    //////////////////////////////////////////////////////////////////////

    logic [FRAME_CNT_W-1:0] frame_timer;

    // high on the last edge of a frame
    logic                   frame_last;

    assign frame_last = (frame_timer == FRAME_CNT_W'(FRAME_CYCLES - 1));

    // starts at zero out of reset, shared by all channels
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
            frame_timer <= '0;
        else if (frame_last)
            frame_timer <= '0;
        else
            frame_timer <= frame_timer + 1'b1;
    end

    //////////////////////////////////////////////////////////////////////
    // running counts and frame totals
    //////////////////////////////////////////////////////////////////////

    logic [NUM_CH-1:0] spike_bits;

    // per-channel counts within the current frame
    count_t            run_cnt   [NUM_CH];

    // totals of the last finished frame
    count_t            frame_cnt [NUM_CH];

    // channel order matches the output order
    assign spike_bits = {i_spike_delayed_twice, i_spike_delayed, i_spike_raw};

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            o_frame_valid <= 1'b0;
            for (int ch = 0; ch < NUM_CH; ch++)
            begin
                run_cnt[ch]   <= '0;
                frame_cnt[ch] <= '0;
            end
        end
        else
        begin
            // single-cycle strobe, nothing holds it
            o_frame_valid <= frame_last;
            for (int ch = 0; ch < NUM_CH; ch++)
            begin
                if (frame_last)
                begin
                    // total includes this edge's sample
                    frame_cnt[ch] <= run_cnt[ch] + count_t'(spike_bits[ch]);
                    run_cnt[ch]   <= '0;
                end
                else
                begin
                    run_cnt[ch] <= run_cnt[ch] + count_t'(spike_bits[ch]);
                end
            end
        end
    end

    // outputs hold until the next strobe
    assign o_count_raw           = frame_cnt[0];
    assign o_count_delayed       = frame_cnt[1];
    assign o_count_delayed_twice = frame_cnt[2];

endmodule

// ==== source/spike_count_history.sv ====
`timescale 1ns/100ps

module spike_count_history
(
    input  logic                    ep50trig,
    input  logic                    reset_global,
    input  logic                    i_frame_valid,
    input  spike_delay_pkg::count_t i_count_raw,
    output spike_delay_pkg::count_t o_count_history
);

    import spike_delay_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // count shift store
    //////////////////////////////////////////////////////////////////////

    // stage 0 newest, last stage oldest
    count_t hist_stage [HISTORY_DEPTH];

    // one shift per frame strobe
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            // zeros stand in for frames before the first one
            for (int i = 0; i < HISTORY_DEPTH; i++)
            begin
                hist_stage[i] <= '0;
            end
        end
        else if (i_frame_valid)
        begin
            hist_stage[0] <= i_count_raw;
            for (int i = 1; i < HISTORY_DEPTH; i++)
            begin
                hist_stage[i] <= hist_stage[i-1];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // output
    //////////////////////////////////////////////////////////////////////

    // read alongside the strobe, before this frame's shift
    // so it shows the raw count from HISTORY_DEPTH frames back
    assign o_count_history = hist_stage[HISTORY_DEPTH-1];

endmodule

// ==== source/spike_delay_top.sv ====
`timescale 1ns/100ps

module spike_delay_top
(
    input  logic                    ep50trig,
    input  logic                    reset_global,
    input  logic                    i_spike,
    output logic                    o_spike_delayed,
    output logic                    o_frame_valid,
    output spike_delay_pkg::count_t o_count_raw,
    output spike_delay_pkg::count_t o_count_delayed,
    output spike_delay_pkg::count_t o_count_delayed_twice,
    output spike_delay_pkg::count_t o_count_history
);

    import spike_delay_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // spike path
    //////////////////////////////////////////////////////////////////////

    logic spike_delayed;
    logic spike_delayed_twice;

    // first delay, its output also leaves the block
    spike_delay_line #(
        .DELAY (SPIKE_DELAY_CYCLES),
        .DEPTH (SPIKE_RING_DEPTH)
    ) delay_first (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_spike      (i_spike),
        .o_spike      (spike_delayed)
    );

    // second delay, chained on the first
    spike_delay_line #(
        .DELAY (SPIKE_DELAY_CYCLES),
        .DEPTH (SPIKE_RING_DEPTH)
    ) delay_second (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_spike      (spike_delayed),
        .o_spike      (spike_delayed_twice)
    );

    assign o_spike_delayed = spike_delayed;

    //////////////////////////////////////////////////////////////////////
    // frame path
    //////////////////////////////////////////////////////////////////////

    spike_frame_counter spike_frame_counter_i (
        .ep50trig              (ep50trig),
        .reset_global          (reset_global),
        .i_spike_raw           (i_spike),
        .i_spike_delayed       (spike_delayed),
        .i_spike_delayed_twice (spike_delayed_twice),
        .o_frame_valid         (o_frame_valid),
        .o_count_raw           (o_count_raw),
        .o_count_delayed       (o_count_delayed),
        .o_count_delayed_twice (o_count_delayed_twice)
    );

    // raw count history, taps the counter outputs
    spike_count_history spike_count_history_i (
        .ep50trig        (ep50trig),
        .reset_global    (reset_global),
        .i_frame_valid   (o_frame_valid),
        .i_count_raw     (o_count_raw),
        .o_count_history (o_count_history)
    );

endmodule

// ==== verification/spike_delay_model.svh ====
`ifndef SPIKE_DELAY_MODEL_SVH
`define SPIKE_DELAY_MODEL_SVH

//////////////////////////////////////////////////////////////////////
// expected stream bits
//////////////////////////////////////////////////////////////////////

// input bit sampled at edge k, zero outside the run
function automatic logic raw_bit(input int k);
    if (k < 1 || k > RUN_EDGES)
        return 1'b0;
    return rec_spike[k];
endfunction

// first delay output after edge k
// zero through the fill period
function automatic logic delayed_bit(input int k);
    return raw_bit(k - SPIKE_DELAY_CYCLES);
endfunction

// second delay output after edge k
// its input at edge j is what the first line left after edge j - 1
function automatic logic delayed_twice_bit(input int k);
    if (k - SPIKE_DELAY_CYCLES < 1)
        return 1'b0;
    return delayed_bit(k - SPIKE_DELAY_CYCLES - 1);
endfunction

//////////////////////////////////////////////////////////////////////
// expected frame counts
//////////////////////////////////////////////////////////////////////

// channel 0 raw, 1 delayed, 2 delayed twice
// a delay output reaches the counter one edge after it was registered
function automatic count_t frame_count(input int n, input int ch);
    count_t sum;
    logic   bit_at;

    sum = '0;
    for (int k = n * FRAME_CYCLES + 1; k <= (n + 1) * FRAME_CYCLES; k++)
    begin
        case (ch)
            0:       bit_at = raw_bit(k);
            1:       bit_at = delayed_bit(k - 1);
            default: bit_at = delayed_twice_bit(k - 1);
        endcase
        sum = sum + count_t'(bit_at);
    end
    return sum;
endfunction

// raw count from HISTORY_DEPTH frames back
// zero while the store still holds reset values
function automatic count_t history_count(input int n);
    if (n < HISTORY_DEPTH)
        return '0;
    return frame_count(n - HISTORY_DEPTH, 0);
endfunction

`endif

// ==== verification/spike_delay_tb.sv ====
`timescale 1ns/100ps

module spike_delay_tb;

    import spike_delay_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // run length
    //////////////////////////////////////////////////////////////////////

    localparam int CLK_HALF_NS    = 20;
    localparam int RESET_CYCLES   = 16;
    localparam int RUN_FRAMES     = 80;
    localparam int RUN_EDGES      = RUN_FRAMES * FRAME_CYCLES;
    // twenty frames of margin past the run
    localparam int TIMEOUT_CYCLES = (RUN_FRAMES + 20) * FRAME_CYCLES;

    logic   ep50trig = 1'b0;
    logic   reset_global;
    logic   i_spike;
    logic   o_spike_delayed;
    logic   o_frame_valid;
    count_t o_count_raw;
    count_t o_count_delayed;
    count_t o_count_delayed_twice;
    count_t o_count_history;

    // driven bit per sample edge
    // index 0 stays unused
    logic   rec_spike [0:RUN_EDGES];

    int     seed         = 0;
    int     edge_num     = 0;
    int     cycle_cnt    = 0;
    int     strobes_seen = 0;
    int     err_reset    = 0;
    int     err_delayed  = 0;
    int     err_strobe   = 0;
    int     err_count    = 0;
    int     err_history  = 0;
    logic   check_done   = 1'b0;

    `include "spike_delay_model.svh"

    spike_delay_top spike_delay_top_i (
        .ep50trig              (ep50trig),
        .reset_global          (reset_global),
        .i_spike               (i_spike),
        .o_spike_delayed       (o_spike_delayed),
        .o_frame_valid         (o_frame_valid),
        .o_count_raw           (o_count_raw),
        .o_count_delayed       (o_count_delayed),
        .o_count_delayed_twice (o_count_delayed_twice),
        .o_count_history       (o_count_history)
    );

    // 40 ns period
    always #CLK_HALF_NS ep50trig = ~ep50trig;

    // edge 1 is the first rising edge after reset release
    always @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
            edge_num <= 0;
        else
            edge_num <= edge_num + 1;
    end

    always @(posedge ep50trig)
    begin
        cycle_cnt <= cycle_cnt + 1;
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus pattern
    //////////////////////////////////////////////////////////////////////

    // bit for edge k depends on the frame it falls in
    function automatic logic next_spike(input int k);
        int frame;
        int rnd;

        frame = (k - 1) / FRAME_CYCLES;
        rnd   = $random(seed);
        // full frames give a count of FRAME_CYCLES
        if (frame == 20 || frame == 21 || frame == 50)
            return 1'b1;
        // silent burst
        if (frame == 22 || frame == 23)
            return 1'b0;
        // sparse firing
        if (frame >= 30 && frame < 40)
            return (rnd & 3) == 0;
        // dense firing
        if (frame >= 60 && frame < 66)
            return (rnd & 3) != 0;
        return rnd[0];
    endfunction

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    // everything still at reset value
    task automatic verify_reset_outputs();
        if (o_spike_delayed !== 1'b0 || o_frame_valid !== 1'b0)
        begin
            $display("Fail at %0t: spike or strobe not low in reset", $time);
            err_reset++;
        end
        if (o_count_raw !== '0 || o_count_delayed !== '0 ||
            o_count_delayed_twice !== '0 || o_count_history !== '0)
        begin
            $display("Fail at %0t: counts not zero in reset", $time);
            err_reset++;
        end
    endtask

    // outputs left by edge k
    task automatic compare_edge_outputs(input int k);
        logic   exp_valid;
        int     frame;
        count_t exp_raw;
        count_t exp_delayed;
        count_t exp_twice;
        count_t exp_history;

        exp_valid = (k % FRAME_CYCLES) == 0;
        // last finished frame
        // -1 before the first one
        frame     = k / FRAME_CYCLES - 1;

        if (o_spike_delayed !== delayed_bit(k))
        begin
            $display("Fail at %0t: o_spike_delayed after edge %0d is %b, expected %b",
                     $time, k, o_spike_delayed, delayed_bit(k));
            err_delayed++;
        end

        if (o_frame_valid !== exp_valid)
        begin
            $display("Fail at %0t: o_frame_valid after edge %0d is %b, expected %b",
                     $time, k, o_frame_valid, exp_valid);
            err_strobe++;
        end
        if (o_frame_valid === 1'b1)
            strobes_seen++;

        // counts hold between strobes
        if (frame < 0)
        begin
            exp_raw     = '0;
            exp_delayed = '0;
            exp_twice   = '0;
        end
        else
        begin
            exp_raw     = frame_count(frame, 0);
            exp_delayed = frame_count(frame, 1);
            exp_twice   = frame_count(frame, 2);
        end

        if (o_count_raw !== exp_raw)
        begin
            $display("Fail at %0t: o_count_raw for frame %0d is %0d, expected %0d",
                     $time, frame, o_count_raw, exp_raw);
            err_count++;
        end
        if (o_count_delayed !== exp_delayed)
        begin
            $display("Fail at %0t: o_count_delayed for frame %0d is %0d, expected %0d",
                     $time, frame, o_count_delayed, exp_delayed);
            err_count++;
        end
        if (o_count_delayed_twice !== exp_twice)
        begin
            $display("Fail at %0t: o_count_delayed_twice for frame %0d is %0d, expected %0d",
                     $time, frame, o_count_delayed_twice, exp_twice);
            err_count++;
        end

        // history is only meaningful with the strobe
        if (exp_valid)
        begin
            exp_history = history_count(frame);
            if (o_count_history !== exp_history)
            begin
                $display("Fail at %0t: o_count_history at frame %0d is %0d, expected %0d",
                         $time, frame, o_count_history, exp_history);
                err_history++;
            end
        end
    endtask

    // outputs are read on the falling edge after each update
    always @(negedge ep50trig)
    begin
        if (edge_num == 0)
            verify_reset_outputs();
        else if (edge_num <= RUN_EDGES)
        begin
            compare_edge_outputs(edge_num);
            if (edge_num == RUN_EDGES)
                check_done = 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // summary
    //////////////////////////////////////////////////////////////////////

    function automatic int total_errors();
        return err_reset + err_delayed + err_strobe + err_count + err_history;
    endfunction

    task automatic report_error_counts();
        $display("errors: reset %0d delayed %0d strobe %0d counts %0d history %0d total %0d",
                 err_reset, err_delayed, err_strobe, err_count, err_history, total_errors());
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        $timeformat(-9, 0, " ns", 0);
        seed         = 24;
        reset_global = 1'b1;
        i_spike      = 1'b0;
        for (int k = 0; k <= RUN_EDGES; k++)
            rec_spike[k] = 1'b0;

        repeat (RESET_CYCLES) @(posedge ep50trig);
        @(negedge ep50trig);
        reset_global = 1'b0;

        // bit for edge k goes out on the falling edge before it
        for (int k = 1; k <= RUN_EDGES; k++)
        begin
            rec_spike[k] = next_spike(k);
            i_spike      = rec_spike[k];
            @(negedge ep50trig);
        end
        i_spike = 1'b0;

        wait (check_done);
        if (strobes_seen != RUN_FRAMES)
        begin
            $display("strobe pulsed %0d times over the run, expected %0d",
                     strobes_seen, RUN_FRAMES);
            err_strobe++;
        end

        report_error_counts();
        if (total_errors() == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

    // hang guard
    initial
    begin
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        $display("timeout: run still going after %0d clock cycles", TIMEOUT_CYCLES);
        report_error_counts();
        $display("** FAIL **");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+verification
source/spike_delay_pkg.sv
source/spike_delay_line.sv
source/spike_frame_counter.sv
source/spike_count_history.sv
source/spike_delay_top.sv
verification/spike_delay_tb.sv

// ==== Makefile ====
# Verilator flow for the spike delay block

VERILATOR ?= verilator
FILELIST  ?= sim.f
TOP       ?= spike_delay_tb
RTL_TOP   ?= spike_delay_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
LFLAGS    ?= --lint-only --timing
PASS_MSG  ?= ** PASS **

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard source/*.sv verification/*.sv verification/*.svh) $(FILELIST)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LFLAGS) -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
